//--- pwm_ctrl_settings.svh
// resolution, bus widths, register offsets and control codes
`ifndef PWM_CTRL_SETTINGS_SVH
`define PWM_CTRL_SETTINGS_SVH

`define PWM_RESOLUTION 32 // counter and period width
`define PWM_ADDR_W     6  // low byte address bits decoded
`define PWM_DATA_W     32

// register byte offsets
`define PWM_REG_CTRL0   6'h00
`define PWM_REG_CTRL1   6'h04
`define PWM_REG_PERIOD0 6'h08
`define PWM_REG_PERIOD1 6'h0c
`define PWM_REG_THRESH0 6'h10
`define PWM_REG_THRESH1 6'h18
`define PWM_REG_OUT0    6'h28 // read only
`define PWM_REG_OUT1    6'h2c // read only

`define PWM_CODE_STANDARD 2'b01 // any other code idles the channel

`endif

//--- pwm_bus_pkg.sv
// bus-side types for address, data word, byte selects and raw control field
`include "pwm_ctrl_settings.svh"

package pwm_bus_pkg;

    typedef logic [`PWM_ADDR_W-1:0]   wb_addr_t;    // register byte address
    typedef logic [`PWM_DATA_W-1:0]   wb_data_t;
    typedef logic [`PWM_DATA_W/8-1:0] wb_sel_t;     // one bit per byte lane

    // control value as stored, before mode decode
    typedef logic [1:0] ctrl_field_t;

endpackage

//--- pwm_chan_pkg.sv
// channel-side types for the counter width and the channel mode
`include "pwm_ctrl_settings.svh"

package pwm_chan_pkg;

    // period, threshold and counter all share this width
    typedef logic [`PWM_RESOLUTION-1:0] pwm_count_t;

    typedef enum logic {
        PWM_IDLE,     // output held low
        PWM_STANDARD  // fixed duty from threshold
    } pwm_mode_t;

endpackage

//--- pwm_chan_if.sv
// pwm_chan_if interface with reg-side and channel-side modports
`timescale 1ns/10ps

interface pwm_chan_if;
    import pwm_chan_pkg::*;

    pwm_mode_t  mode;
    pwm_count_t period;
    pwm_count_t threshold;
    logic       level;     // registered pin level, read back by the bus

    // register bank drives configuration
    modport reg_mp (
        output mode,
        output period,
        output threshold,
        input  level
    );

    modport chan_mp (
        input  mode,
        input  period,
        input  threshold,
        output level
    );

endinterface

//--- pwm_reg_bank.sv
// pwm_reg_bank module: Wishbone slave, channel registers, read mux, ack and mode decode
`timescale 1ns/10ps
`include "pwm_ctrl_settings.svh"

module pwm_reg_bank (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  pwm_bus_pkg::wb_addr_t wb_adr_i,
    input  pwm_bus_pkg::wb_data_t wb_dat_i,
    input  logic                  wb_we_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  pwm_bus_pkg::wb_sel_t  wb_sel_i,
    output pwm_bus_pkg::wb_data_t wb_dat_o,
    output logic                  wb_ack_o,
    pwm_chan_if.reg_mp            ch0_o,
    pwm_chan_if.reg_mp            ch1_o
);
    import pwm_bus_pkg::*;
    import pwm_chan_pkg::*;

    ctrl_field_t ctrl0_q;
    ctrl_field_t ctrl1_q;
    pwm_count_t  period0_q;
    pwm_count_t  period1_q;
    pwm_count_t  thresh0_q;
    pwm_count_t  thresh1_q;

    wb_data_t dat_q;   // holds until next read
    logic     ack_q;
    logic     mapped;
    logic     req;
    logic     wr_req;
    logic     rd_req;
    wb_data_t rd_data;

    // replace only the byte lanes whose select bit is set
    function automatic wb_data_t merge_lanes(wb_data_t old_val, wb_data_t new_val,
                                             wb_sel_t sel);
        wb_data_t res;
        res = old_val;
        for (int k = 0; k < `PWM_DATA_W/8; k++) begin
            if (sel[k]) begin
                res[8*k +: 8] = new_val[8*k +: 8];
            end
        end
        return res;
    endfunction

    // the only place the control code gets meaning
    function automatic pwm_mode_t decode_mode(ctrl_field_t code);
        return (code == `PWM_CODE_STANDARD) ? PWM_STANDARD : PWM_IDLE;
    endfunction

    always_comb begin
        case (wb_adr_i)
            `PWM_REG_CTRL0,
            `PWM_REG_CTRL1,
            `PWM_REG_PERIOD0,
            `PWM_REG_PERIOD1,
            `PWM_REG_THRESH0,
            `PWM_REG_THRESH1,
            `PWM_REG_OUT0,
            `PWM_REG_OUT1: mapped = 1'b1;
            default:       mapped = 1'b0; // no ack, master must time out
        endcase
    end

    // ack low gate keeps a held strobe from being taken twice
    assign req    = wb_cyc_i && wb_stb_i && !ack_q && mapped;
    assign wr_req = req && wb_we_i;
    assign rd_req = req && !wb_we_i;

    always_comb begin
        case (wb_adr_i)
            `PWM_REG_CTRL0:   rd_data = wb_data_t'(ctrl0_q);
            `PWM_REG_CTRL1:   rd_data = wb_data_t'(ctrl1_q);
            `PWM_REG_PERIOD0: rd_data = period0_q;
            `PWM_REG_PERIOD1: rd_data = period1_q;
            `PWM_REG_THRESH0: rd_data = thresh0_q;
            `PWM_REG_THRESH1: rd_data = thresh1_q;
            `PWM_REG_OUT0:    rd_data = wb_data_t'(ch0_o.level);
            `PWM_REG_OUT1:    rd_data = wb_data_t'(ch1_o.level);
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= req; // single pulse on the request edge
            if (rd_req) begin
                dat_q <= rd_data;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl0_q   <= '0;
            ctrl1_q   <= '0;
            period0_q <= '0;
            period1_q <= '0;
            thresh0_q <= '0;
            thresh1_q <= '0;
        end else if (wr_req) begin
            case (wb_adr_i)
                `PWM_REG_CTRL0: begin
                    if (wb_sel_i[0]) begin
                        ctrl0_q <= wb_dat_i[1:0];
                    end
                end
                `PWM_REG_CTRL1: begin
                    if (wb_sel_i[0]) begin
                        ctrl1_q <= wb_dat_i[1:0];
                    end
                end
                `PWM_REG_PERIOD0: period0_q <= merge_lanes(period0_q, wb_dat_i, wb_sel_i);
                `PWM_REG_PERIOD1: period1_q <= merge_lanes(period1_q, wb_dat_i, wb_sel_i);
                `PWM_REG_THRESH0: thresh0_q <= merge_lanes(thresh0_q, wb_dat_i, wb_sel_i);
                `PWM_REG_THRESH1: thresh1_q <= merge_lanes(thresh1_q, wb_dat_i, wb_sel_i);
                default: ; // output bits are read only, write still acks
            endcase
        end
    end

    assign wb_dat_o = dat_q;
    assign wb_ack_o = ack_q;

    // configuration goes straight out, no extra stage
    assign ch0_o.mode      = decode_mode(ctrl0_q);
    assign ch0_o.period    = period0_q;
    assign ch0_o.threshold = thresh0_q;
    assign ch1_o.mode      = decode_mode(ctrl1_q);
    assign ch1_o.period    = period1_q;
    assign ch1_o.threshold = thresh1_q;

    // a master holding stb through ack must not get a second ack
    a_ack_single: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_ack_o |=> !wb_ack_o
    );

endmodule

//--- pwm_channel.sv
// pwm_channel module: period counter, threshold compare and registered output
`timescale 1ns/10ps
`include "pwm_ctrl_settings.svh"

module pwm_channel (
    input  logic        clk_i,
    input  logic        rst_i,
    pwm_chan_if.chan_mp cfg_i,
    output logic        pwm_o
);
    import pwm_chan_pkg::*;

    pwm_count_t count_q;
    logic       running;
    logic       wrap;
    logic       raw_level;
    logic       pwm_q;

    assign running = (cfg_i.mode == PWM_STANDARD);

    // period zero holds the counter at zero
    // >= rather than == so a shrunk period wraps at once
    assign wrap = (cfg_i.period == '0) ||
                  (count_q >= cfg_i.period - pwm_count_t'(1));

    // high for the first threshold counts of each period
    assign raw_level = running && (count_q < cfg_i.threshold);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (!running) begin
            count_q <= '0; // idle restarts the period
        end else if (wrap) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + pwm_count_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pwm_q <= 1'b0;
        end else begin
            pwm_q <= raw_level; // one cycle behind the compare
        end
    end

    assign pwm_o       = pwm_q;
    assign cfg_i.level = pwm_q; // readback matches the pin

    // idle decoded in the register bank must reach the pin one edge later
    a_idle_low: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (cfg_i.mode == PWM_IDLE) |=> !pwm_o
    );

endmodule

//--- pwm_ctrl.sv
// pwm_ctrl top module: register bank and two PWM channels
`timescale 1ns/10ps
`include "pwm_ctrl_settings.svh"

module pwm_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  pwm_bus_pkg::wb_addr_t wb_adr_i,
    input  pwm_bus_pkg::wb_data_t wb_dat_i,
    input  logic                  wb_we_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  pwm_bus_pkg::wb_sel_t  wb_sel_i,
    output pwm_bus_pkg::wb_data_t wb_dat_o,
    output logic                  wb_ack_o,
    output logic                  pwm0_o,
    output logic                  pwm1_o
);

    // one link per channel
    pwm_chan_if ch0 ();
    pwm_chan_if ch1 ();

    pwm_reg_bank u_regs (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .ch0_o    (ch0.reg_mp),
        .ch1_o    (ch1.reg_mp)
    );

    pwm_channel u_ch0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cfg_i (ch0.chan_mp),
        .pwm_o (pwm0_o)
    );

    pwm_channel u_ch1 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cfg_i (ch1.chan_mp),
        .pwm_o (pwm1_o)
    );

endmodule

//--- pwm_ctrl_checker.sv
// checker module with register model, ack and read checks, duty measurement and per-test report
`timescale 1ns/10ps
`include "pwm_ctrl_settings.svh"

module pwm_ctrl_checker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  int                    test_i,
    input  pwm_bus_pkg::wb_addr_t wb_adr_i,
    input  pwm_bus_pkg::wb_data_t wb_dat_i,
    input  logic                  wb_we_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  pwm_bus_pkg::wb_sel_t  wb_sel_i,
    input  pwm_bus_pkg::wb_data_t dut_dat_i,
    input  logic                  dut_ack_i,
    input  logic                  pwm0_i,
    input  logic                  pwm1_i,
    output int                    err_count_o,
    output logic                  measuring_o
);
    import pwm_bus_pkg::*;

    ctrl_field_t ctrl_m [2];
    wb_data_t    period_m [2];
    wb_data_t    thresh_m [2];

    logic     taken_prev;
    logic     rd_prev;   // read taken on the previous edge
    wb_data_t rd_exp;
    wb_addr_t rd_adr;
    int       idle_run [2];
    int       prev_test = 0;
    int       test_errs = 0;
    int       total_errs = 0;

    logic meas_on = 1'b0;
    int   meas_ch;
    int   meas_p;
    int   meas_t;
    int   meas_k;
    int   meas_high;

    function automatic string test_name(int n);
        case (n)
            1:       return "reset_state";
            2:       return "register_readback";
            3:       return "duty_cycle";
            4:       return "channel_independence";
            5:       return "unmapped_address";
            default: return "no_test";
        endcase
    endfunction

    function automatic logic offset_mapped(wb_addr_t a);
        return a inside {`PWM_REG_CTRL0, `PWM_REG_CTRL1, `PWM_REG_PERIOD0, `PWM_REG_PERIOD1,
                         `PWM_REG_THRESH0, `PWM_REG_THRESH1, `PWM_REG_OUT0, `PWM_REG_OUT1};
    endfunction

    // lane k follows the new word only where sel[k] is set
    function automatic wb_data_t apply_byte_selects(wb_data_t old_w, wb_data_t new_w,
                                                    wb_sel_t sel);
        wb_data_t w;
        w = old_w;
        for (int k = 0; k < 4; k++) begin
            if (sel[k]) w[8*k +: 8] = new_w[8*k +: 8];
        end
        return w;
    endfunction

    function automatic wb_data_t expected_read(wb_addr_t a, logic [1:0] pins);
        case (a)
            `PWM_REG_CTRL0:   return {30'b0, ctrl_m[0]};
            `PWM_REG_CTRL1:   return {30'b0, ctrl_m[1]};
            `PWM_REG_PERIOD0: return period_m[0];
            `PWM_REG_PERIOD1: return period_m[1];
            `PWM_REG_THRESH0: return thresh_m[0];
            `PWM_REG_THRESH1: return thresh_m[1];
            `PWM_REG_OUT0:    return {31'b0, pins[0]};
            default:          return {31'b0, pins[1]};
        endcase
    endfunction

    task automatic value_error(string what, wb_data_t exp, wb_data_t act);
        $display("error %s expected %h actual %h in %s", test_name(test_i), exp, act, what);
        test_errs++;
        total_errs++;
    endtask

    task automatic fault(string msg);
        $display("fault in %s: %s", test_name(test_i), msg);
        test_errs++;
        total_errs++;
    endtask

    // checks use pre-edge values and the model updates last
    always @(posedge clk_i) begin
        logic       taken;
        logic [1:0] pins;
        int         want;
        pins = {pwm1_i, pwm0_i};
        if (test_i != prev_test) begin
            if (prev_test != 0) begin
                $display("test %0d %s finished with %0d errors", prev_test,
                         test_name(prev_test), test_errs);
            end
            prev_test = test_i;
            test_errs = 0;
        end
        if (rst_i) begin
            ctrl_m     = '{default: '0};
            period_m   = '{default: '0};
            thresh_m   = '{default: '0};
            idle_run   = '{default: 0};
            taken_prev = 1'b0;
            rd_prev    = 1'b0;
            meas_on    = 1'b0;
        end else begin
            taken = wb_cyc_i && wb_stb_i && !dut_ack_i && offset_mapped(wb_adr_i);
            if (taken_prev && dut_ack_i !== 1'b1) fault("no ack in the cycle after a request");
            if (!taken_prev && dut_ack_i !== 1'b0) fault("ack seen without a request");
            if (rd_prev && dut_ack_i && dut_dat_i !== rd_exp) begin
                value_error($sformatf("read of offset %h", rd_adr), rd_exp, dut_dat_i);
            end
            for (int c = 0; c < 2; c++) begin
                idle_run[c] = (ctrl_m[c] == `PWM_CODE_STANDARD) ? 0 : idle_run[c] + 1;
                if (idle_run[c] >= 2 && pins[c] !== 1'b0) begin
                    fault($sformatf("channel %0d output high while idle", c));
                end
            end
            if (meas_on) begin
                meas_k++;
                if (meas_k > 2*meas_p && pins[meas_ch]) meas_high++;
                if (meas_k == 5*meas_p) begin
                    want = 3 * ((meas_t < meas_p) ? meas_t : meas_p);
                    if (meas_high != want) begin
                        value_error($sformatf(
                                        "high count of channel %0d, period %0d, threshold %0d",
                                        meas_ch, meas_p, meas_t),
                                    want, meas_high);
                    end
                    meas_on = 1'b0;
                end
            end
            rd_prev = taken && !wb_we_i;
            if (rd_prev) begin
                rd_exp = expected_read(wb_adr_i, pins);
                rd_adr = wb_adr_i;
            end
            if (taken && wb_we_i) begin
                case (wb_adr_i)
                    `PWM_REG_CTRL0:   if (wb_sel_i[0]) ctrl_m[0] = wb_dat_i[1:0];
                    `PWM_REG_CTRL1:   if (wb_sel_i[0]) ctrl_m[1] = wb_dat_i[1:0];
                    `PWM_REG_PERIOD0: period_m[0] = apply_byte_selects(period_m[0], wb_dat_i,
                                                                       wb_sel_i);
                    `PWM_REG_PERIOD1: period_m[1] = apply_byte_selects(period_m[1], wb_dat_i,
                                                                       wb_sel_i);
                    `PWM_REG_THRESH0: thresh_m[0] = apply_byte_selects(thresh_m[0], wb_dat_i,
                                                                       wb_sel_i);
                    `PWM_REG_THRESH1: thresh_m[1] = apply_byte_selects(thresh_m[1], wb_dat_i,
                                                                       wb_sel_i);
                    default: ;
                endcase
                // duty window starts at the edge that takes the mode write
                if (test_i == 3 && wb_sel_i[0] && wb_dat_i[1:0] == `PWM_CODE_STANDARD &&
                    (wb_adr_i == `PWM_REG_CTRL0 || wb_adr_i == `PWM_REG_CTRL1)) begin
                    meas_on   = 1'b1;
                    meas_ch   = (wb_adr_i == `PWM_REG_CTRL1) ? 1 : 0;
                    meas_p    = period_m[meas_ch];
                    meas_t    = thresh_m[meas_ch];
                    meas_k    = 0;
                    meas_high = 0;
                end
            end
            taken_prev = taken;
        end
    end

    assign err_count_o = total_errs;
    assign measuring_o = meas_on;

endmodule

//--- tb_pwm_ctrl.sv
// testbench top with clock, reset, seeded random Wishbone master and test sequence
`timescale 1ns/10ps
`include "pwm_ctrl_settings.svh"

module tb_pwm_ctrl;
    import pwm_bus_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RW_WRITES    = 150;
    localparam int DUTY_PAIRS   = 6;
    localparam int IDLE_CODES   = 3;

    logic     clk_i;
    logic     rst_i;
    wb_addr_t wb_adr_i;
    wb_data_t wb_dat_i;
    logic     wb_we_i;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    wb_sel_t  wb_sel_i;
    wb_data_t wb_dat_o;
    logic     wb_ack_o;
    logic     pwm0_o;
    logic     pwm1_o;

    int     test_num;
    int     err_count;
    logic   measuring;
    integer seed = 32'h6f3898cd;
    int     cycle_count = 0;
    int     cycle_limit;
    int     duty_p [2][DUTY_PAIRS];
    int     duty_t [2][DUTY_PAIRS];
    int     solo_p [IDLE_CODES];
    int     solo_t [IDLE_CODES];

    wb_addr_t all_offsets [8] = '{`PWM_REG_CTRL0, `PWM_REG_CTRL1, `PWM_REG_PERIOD0,
        `PWM_REG_PERIOD1, `PWM_REG_THRESH0, `PWM_REG_THRESH1, `PWM_REG_OUT0, `PWM_REG_OUT1};
    wb_addr_t rw_offsets [6] = '{`PWM_REG_CTRL0, `PWM_REG_CTRL1, `PWM_REG_PERIOD0,
        `PWM_REG_PERIOD1, `PWM_REG_THRESH0, `PWM_REG_THRESH1};
    ctrl_field_t idle_codes [IDLE_CODES] = '{2'b00, 2'b10, 2'b11};

    pwm_ctrl dut (.*);

    pwm_ctrl_checker u_chk (
        .clk_i (clk_i), .rst_i (rst_i), .test_i (test_num),
        .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_we_i (wb_we_i),
        .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_sel_i (wb_sel_i),
        .dut_dat_i (wb_dat_o), .dut_ack_i (wb_ack_o),
        .pwm0_i (pwm0_o), .pwm1_i (pwm1_o),
        .err_count_o (err_count), .measuring_o (measuring)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // bus goes quiet with random values on the unused lines
    task automatic drop_bus();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'($random(seed));
        wb_adr_i = wb_addr_t'($random(seed));
        wb_dat_i = wb_data_t'($random(seed));
        wb_sel_i = wb_sel_t'($random(seed));
    endtask

    task automatic bus_access(logic we, wb_addr_t addr, wb_data_t data, wb_sel_t sel);
        @(negedge clk_i);
        wb_adr_i = addr;
        wb_dat_i = data;
        wb_sel_i = sel;
        wb_we_i  = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        do begin
            @(negedge clk_i);
        end while (wb_ack_o !== 1'b1);
        drop_bus();
    endtask

    task automatic bus_write(wb_addr_t addr, wb_data_t data, wb_sel_t sel);
        bus_access(1'b1, addr, data, sel);
    endtask

    task automatic bus_read(wb_addr_t addr);
        bus_access(1'b0, addr, wb_data_t'($random(seed)), wb_sel_t'($random(seed)));
    endtask

    task automatic unmapped_probe(wb_addr_t addr);
        @(negedge clk_i);
        wb_adr_i = addr;
        wb_we_i  = 1'($random(seed));
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        repeat (4) @(negedge clk_i);
        drop_bus();
    endtask

    function automatic wb_data_t ctrl_word(ctrl_field_t code);
        wb_data_t word;
        word      = wb_data_t'($random(seed));
        word[1:0] = code;  // junk above the field
        return word;
    endfunction

    initial begin
        int budget;
        wb_addr_t adr;
        clk_i    = 1'b0;
        rst_i    = 1'b1;
        test_num = 0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;

        // 8 + 2*150 + 36 + 27 + 4 accesses, plus waits and duty windows
        budget = RESET_CYCLES + 4 * 375 + 16;
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < DUTY_PAIRS; i++) begin
                duty_p[c][i] = rand_range(1, 40);
                duty_t[c][i] = rand_range(0, 45);
                budget += 5 * duty_p[c][i];
            end
        end
        for (int i = 0; i < IDLE_CODES; i++) begin
            solo_p[i] = rand_range(1, 40);
            solo_t[i] = rand_range(0, 45);
            budget += 2 * solo_p[i] + 12;
        end
        cycle_limit = 2 * budget;

        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;

        test_num = 1;
        foreach (all_offsets[i]) bus_read(all_offsets[i]);

        test_num = 2;
        repeat (RW_WRITES) begin
            adr = rw_offsets[rand_range(0, 5)];
            bus_write(adr, wb_data_t'($random(seed)), wb_sel_t'($random(seed)));
            bus_read(adr);
        end

        test_num = 3;
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < DUTY_PAIRS; i++) begin
                bus_write(c ? `PWM_REG_PERIOD1 : `PWM_REG_PERIOD0, duty_p[c][i], 4'hf);
                bus_write(c ? `PWM_REG_THRESH1 : `PWM_REG_THRESH0, duty_t[c][i], 4'hf);
                bus_write(c ? `PWM_REG_CTRL1 : `PWM_REG_CTRL0,
                          ctrl_word(`PWM_CODE_STANDARD), 4'hf);
                while (measuring) @(negedge clk_i);
            end
        end

        test_num = 4;
        for (int i = 0; i < IDLE_CODES; i++) begin
            bus_write(`PWM_REG_CTRL1, ctrl_word(idle_codes[i]), 4'hf);
            bus_write(`PWM_REG_PERIOD0, solo_p[i], 4'hf);
            bus_write(`PWM_REG_THRESH0, solo_t[i], 4'hf);
            bus_write(`PWM_REG_CTRL0, ctrl_word(`PWM_CODE_STANDARD), 4'hf);
            repeat (2 * solo_p[i]) @(negedge clk_i);
            bus_read(`PWM_REG_OUT1);
            repeat (4) begin
                repeat (rand_range(0, 3)) @(negedge clk_i);
                bus_read(`PWM_REG_OUT0);
            end
        end

        test_num = 5;
        unmapped_probe(6'h30);
        bus_read(`PWM_REG_PERIOD0);
        unmapped_probe(6'h3c);
        bus_read(`PWM_REG_THRESH1);

        test_num = 0;
        repeat (2) @(negedge clk_i);
        $display("tests run: 5, errors: %0d", err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- pwm_ctrl.f
+incdir+.
pwm_bus_pkg.sv
pwm_chan_pkg.sv
pwm_chan_if.sv
pwm_reg_bank.sv
pwm_channel.sv
pwm_ctrl.sv
pwm_ctrl_checker.sv
tb_pwm_ctrl.sv
